/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/conv_ctrl_pkg.sv */
`default_nettype none

package conv_ctrl_pkg;

    localparam int max_ifm_w = 16;
    localparam int max_kernel_w = 3;

    localparam int kw_w = $clog2(max_kernel_w + 1);
    localparam int iw_w = $clog2(max_ifm_w + 1);
    localparam int stride_w = 2;

    typedef enum logic [1:0] {idle, run, drain, done} ctrl_state_t;

    typedef struct packed {
        logic [kw_w-1:0]     kernel_w;
        logic [iw_w-1:0]     ifm_w;
        logic [stride_w-1:0] stride;
    } conv_cfg_t;

    typedef logic [7:0] ofm_idx_t;
    // up to 16x16 outputs, one bit more than the index
    typedef logic [8:0] px_count_t;

    function automatic logic [iw_w-1:0] ofm_width(conv_cfg_t c);
        return (c.ifm_w - iw_w'(c.kernel_w)) / iw_w'(c.stride) + iw_w'(1);
    endfunction

endpackage

`default_nettype wire

/* common/conv_data_pkg.sv */
`default_nettype none

package conv_data_pkg;

    // one element per output channel
    localparam int num_pe = 4;
    localparam int pe_sel_w = $clog2(num_pe);

    localparam int lane_w = 8;
    localparam int num_lanes = 4;
    localparam int pixel_w = lane_w * num_lanes;

    localparam int ifm_addr_w = 8;
    localparam int ifm_depth = 256;
    localparam int wgt_addr_w = 4;
    localparam int wgt_depth = 16;

    // requantize from Q8.8 products back to Q4.4
    localparam int acc_shift = 4;
    localparam int relu6_max = 96;

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic signed [lane_w-1:0] lane_t;
    typedef logic [num_pe*lane_w-1:0] ofm_word_t;
    typedef logic signed [31:0] acc_t;

endpackage

`default_nettype wire

/* common/conv_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface conv_rd_if;
    import conv_data_pkg::*;

    logic                  rd_en;
    logic [ifm_addr_w-1:0] ifm_addr;
    logic [wgt_addr_w-1:0] wgt_addr;
    // window markers, issued together with the read
    logic                  first;
    logic                  last;
    // same markers, aligned to memory read data
    logic                  pe_first;
    logic                  pe_last;

    modport gen (output rd_en, ifm_addr, wgt_addr, first, last);
    modport mem (
        input  rd_en, ifm_addr, wgt_addr, first, last,
        output pe_first, pe_last
    );
    modport pe (input pe_first, pe_last);

endinterface

`default_nettype wire

/* control/address_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module address_generator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     go,
    input  conv_ctrl_pkg::conv_cfg_t cfg,
    input  conv_ctrl_pkg::px_count_t total_px,
    output logic                     gen_done,
    conv_rd_if.gen                   rd
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    logic                  active;
    logic [kw_w-1:0]       kx;
    logic [kw_w-1:0]       ky;
    logic [iw_w-1:0]       ox;
    logic [iw_w-1:0]       oy;
    px_count_t             win_cnt;
    logic [iw_w-1:0]       ofm_w;
    logic                  last_kx;
    logic                  last_ky;
    logic                  last_ox;
    logic                  first_term;
    logic                  last_term;
    logic                  final_term;
    logic [ifm_addr_w-1:0] row_c;
    logic [ifm_addr_w-1:0] col_c;
    logic [ifm_addr_w-1:0] ifm_addr_c;
    logic [wgt_addr_w-1:0] wgt_addr_c;

    assign ofm_w      = ofm_width(cfg);
    assign last_kx    = (kx == cfg.kernel_w - 1'b1);
    assign last_ky    = (ky == cfg.kernel_w - 1'b1);
    assign last_ox    = (ox == ofm_w - 1'b1);
    assign first_term = (kx == '0) && (ky == '0);
    assign last_term  = last_kx && last_ky;
    assign final_term = last_term && (win_cnt == total_px - 1'b1);

    // (oy*stride + ky) * ifm_w + ox*stride + kx
    assign row_c = ifm_addr_w'(oy) * ifm_addr_w'(cfg.stride) + ifm_addr_w'(ky);
    assign col_c = ifm_addr_w'(ox) * ifm_addr_w'(cfg.stride) + ifm_addr_w'(kx);
    assign ifm_addr_c = row_c * ifm_addr_w'(cfg.ifm_w) + col_c;
    assign wgt_addr_c = wgt_addr_w'(ky) * wgt_addr_w'(cfg.kernel_w) + wgt_addr_w'(kx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            kx       <= '0;
            ky       <= '0;
            ox       <= '0;
            oy       <= '0;
            win_cnt  <= '0;
            rd.rd_en <= 1'b0;
            rd.first <= 1'b0;
            rd.last  <= 1'b0;
            gen_done <= 1'b0;
        end else begin
            rd.rd_en <= active;
            rd.first <= active && first_term;
            rd.last  <= active && last_term;
            gen_done <= active && final_term;
            if (go) begin
                active  <= 1'b1;
                kx      <= '0;
                ky      <= '0;
                ox      <= '0;
                oy      <= '0;
                win_cnt <= '0;
            end else if (active) begin
                if (final_term) begin
                    active <= 1'b0;
                end
                // kx fastest, then ky, then output column, then row
                if (last_kx) begin
                    kx <= '0;
                    if (last_ky) begin
                        ky      <= '0;
                        win_cnt <= win_cnt + 1'b1;
                        if (last_ox) begin
                            ox <= '0;
                            oy <= oy + 1'b1;
                        end else begin
                            ox <= ox + 1'b1;
                        end
                    end else begin
                        ky <= ky + 1'b1;
                    end
                end else begin
                    kx <= kx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd.ifm_addr <= ifm_addr_c;
        rd.wgt_addr <= wgt_addr_c;
    end

endmodule

`default_nettype wire

/* control/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_req,
    input  conv_ctrl_pkg::conv_cfg_t  cfg_in,
    input  logic                      gen_done,
    input  logic                      ofm_valid,
    output logic                      go,
    output conv_ctrl_pkg::conv_cfg_t  cfg,
    output logic                      busy,
    output logic                      start_ack,
    output conv_ctrl_pkg::px_count_t  total_px
);
    import conv_ctrl_pkg::*;

    ctrl_state_t     state;
    px_count_t       px_cnt;
    logic [iw_w-1:0] ofm_w;
    logic            last_px;

    // output grid is square
    assign ofm_w    = ofm_width(cfg);
    assign total_px = px_count_t'(ofm_w) * px_count_t'(ofm_w);
    assign last_px  = ofm_valid && (px_cnt + 1'b1 == total_px);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= idle;
            go     <= 1'b0;
            px_cnt <= '0;
        end else begin
            go <= 1'b0;
            if (ofm_valid) begin
                px_cnt <= px_cnt + 1'b1;
            end
            case (state)
                idle: begin
                    if (start_req) begin
                        state  <= run;
                        go     <= 1'b1;
                        px_cnt <= '0;
                    end
                end
                run: begin
                    if (gen_done) begin
                        state <= drain;
                    end
                end
                // wait for the final pixel to leave the output register
                drain: begin
                    if (last_px) begin
                        state <= done;
                    end
                end
                done: begin
                    if (!start_req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start_req) begin
            cfg <= cfg_in;
        end
    end

    assign busy      = (state == run) || (state == drain);
    assign start_ack = (state == done);

endmodule

`default_nettype wire

/* hw/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 ifm_wr_en,
    input  logic [conv_data_pkg::ifm_addr_w-1:0] ifm_wr_addr,
    input  conv_data_pkg::pixel_t                ifm_wr_data,
    input  logic                                 wgt_wr_en,
    input  logic [conv_data_pkg::pe_sel_w-1:0]   wgt_wr_pe,
    input  logic [conv_data_pkg::wgt_addr_w-1:0] wgt_wr_addr,
    input  conv_data_pkg::pixel_t                wgt_wr_data,
    input  logic [conv_ctrl_pkg::kw_w-1:0]       kernel_w,
    input  logic [conv_ctrl_pkg::iw_w-1:0]       ifm_w,
    input  logic [conv_ctrl_pkg::stride_w-1:0]   stride,
    input  logic                                 start_req,
    output logic                                 start_ack,
    output logic                                 busy,
    output logic                                 ofm_valid,
    output conv_data_pkg::ofm_word_t             ofm_data,
    output conv_ctrl_pkg::ofm_idx_t              ofm_idx
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    conv_cfg_t cfg_in;
    conv_cfg_t cfg;
    px_count_t total_px;
    logic      go;
    logic      gen_done;
    pixel_t    ifm_q;
    pixel_t    wgt_q [num_pe];
    logic      pe_valid;
    acc_t      acc [num_pe];

    conv_rd_if rd_bus ();

    assign cfg_in = '{kernel_w: kernel_w, ifm_w: ifm_w, stride: stride};

    control_unit u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_req),
        .cfg_in    (cfg_in),
        .gen_done  (gen_done),
        .ofm_valid (ofm_valid),
        .go        (go),
        .cfg       (cfg),
        .busy      (busy),
        .start_ack (start_ack),
        .total_px  (total_px)
    );

    address_generator u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .go       (go),
        .cfg      (cfg),
        .total_px (total_px),
        .gen_done (gen_done),
        .rd       (rd_bus.gen)
    );

    feature_buffer u_fbuf (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifm_wr_en   (ifm_wr_en),
        .ifm_wr_addr (ifm_wr_addr),
        .ifm_wr_data (ifm_wr_data),
        .wgt_wr_en   (wgt_wr_en),
        .wgt_wr_pe   (wgt_wr_pe),
        .wgt_wr_addr (wgt_wr_addr),
        .wgt_wr_data (wgt_wr_data),
        .ifm_q       (ifm_q),
        .wgt_q       (wgt_q),
        .rd          (rd_bus.mem)
    );

    pe_array u_pe (
        .clk      (clk),
        .rst_n    (rst_n),
        .ifm_q    (ifm_q),
        .wgt_q    (wgt_q),
        .pe_rd    (rd_bus.pe),
        .pe_valid (pe_valid),
        .acc      (acc)
    );

    activation_stage u_act (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .pe_valid  (pe_valid),
        .acc       (acc),
        .ofm_valid (ofm_valid),
        .ofm_data  (ofm_data),
        .ofm_idx   (ofm_idx)
    );

endmodule

`default_nettype wire

/* hw/feature_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module feature_buffer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 ifm_wr_en,
    input  logic [conv_data_pkg::ifm_addr_w-1:0] ifm_wr_addr,
    input  conv_data_pkg::pixel_t                ifm_wr_data,
    input  logic                                 wgt_wr_en,
    input  logic [conv_data_pkg::pe_sel_w-1:0]   wgt_wr_pe,
    input  logic [conv_data_pkg::wgt_addr_w-1:0] wgt_wr_addr,
    input  conv_data_pkg::pixel_t                wgt_wr_data,
    output conv_data_pkg::pixel_t                ifm_q,
    output conv_data_pkg::pixel_t                wgt_q [conv_data_pkg::num_pe],
    conv_rd_if.mem                               rd
);
    import conv_data_pkg::*;

    pixel_t ifm_mem [ifm_depth];
    pixel_t wgt_mem [num_pe][wgt_depth];

    always_ff @(posedge clk) begin
        if (ifm_wr_en) begin
            ifm_mem[ifm_wr_addr] <= ifm_wr_data;
        end
        if (rd.rd_en) begin
            ifm_q <= ifm_mem[rd.ifm_addr];
        end
    end

    // all elements read the same weight address
    always_ff @(posedge clk) begin
        if (wgt_wr_en) begin
            wgt_mem[wgt_wr_pe][wgt_wr_addr] <= wgt_wr_data;
        end
        for (int p = 0; p < num_pe; p++) begin
            if (rd.rd_en) begin
                wgt_q[p] <= wgt_mem[p][rd.wgt_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd.pe_first <= 1'b0;
            rd.pe_last  <= 1'b0;
        end else begin
            rd.pe_first <= rd.first;
            rd.pe_last  <= rd.last;
        end
    end

endmodule

`default_nettype wire

/* pe_array/activation_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module activation_stage (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 go,
    input  logic                                 pe_valid,
    input  conv_data_pkg::acc_t                  acc [conv_data_pkg::num_pe],
    output logic                                 ofm_valid,
    output conv_data_pkg::ofm_word_t             ofm_data,
    output logic [conv_data_pkg::ifm_addr_w-1:0] ofm_idx
);
    import conv_data_pkg::*;

    ofm_word_t             act_word;
    logic [ifm_addr_w-1:0] idx_cnt;

    // requantize, then relu6 clamp per channel
    always_comb begin
        acc_t shifted;
        for (int p = 0; p < num_pe; p++) begin
            shifted = acc[p] >>> acc_shift;
            if (shifted < 0) begin
                act_word[p*lane_w +: lane_w] = '0;
            end else if (shifted > relu6_max) begin
                act_word[p*lane_w +: lane_w] = lane_w'(relu6_max);
            end else begin
                act_word[p*lane_w +: lane_w] = shifted[lane_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pe_valid) begin
            ofm_data <= act_word;
        end
    end

    // index restarts with every run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ofm_valid <= 1'b0;
            ofm_idx   <= '0;
            idx_cnt   <= '0;
        end else begin
            ofm_valid <= pe_valid;
            if (go) begin
                idx_cnt <= '0;
            end else if (pe_valid) begin
                ofm_idx <= idx_cnt;
                idx_cnt <= idx_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* pe_array/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  conv_data_pkg::pixel_t ifm_q,
    input  conv_data_pkg::pixel_t wgt_q [conv_data_pkg::num_pe],
    conv_rd_if.pe                 pe_rd,
    output logic                  pe_valid,
    output conv_data_pkg::acc_t   acc [conv_data_pkg::num_pe]
);
    import conv_data_pkg::*;

    acc_t term_sum [num_pe];
    acc_t acc_r [num_pe];

    // four signed lane products per element
    always_comb begin
        lane_t a;
        lane_t b;
        for (int p = 0; p < num_pe; p++) begin
            term_sum[p] = '0;
            for (int l = 0; l < num_lanes; l++) begin
                a = lane_t'(ifm_q[l*lane_w +: lane_w]);
                b = lane_t'(wgt_q[p][l*lane_w +: lane_w]);
                term_sum[p] = term_sum[p] + acc_t'(a) * acc_t'(b);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < num_pe; p++) begin
            acc_r[p] <= pe_rd.pe_first ? term_sum[p] : acc_r[p] + term_sum[p];
        end
    end

    // sum is complete the cycle after the window's last term
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pe_valid <= 1'b0;
        end else begin
            pe_valid <= pe_rd.pe_last;
        end
    end

    assign acc = acc_r;

endmodule

`default_nettype wire

/* sim.f */
common/conv_data_pkg.sv
common/conv_ctrl_pkg.sv
common/conv_rd_if.sv
hw/feature_buffer.sv
control/control_unit.sv
control/address_generator.sv
pe_array/pe_array.sv
pe_array/activation_stage.sv
hw/conv_top.sv
verif/tb_clock_gen.sv
verif/tb_conv_top.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;

    localparam int shift_q = 4;
    localparam int act_max = 96;
    localparam int wait_limit = 2000;

    logic        clk;
    logic        rst_n;
    logic        ifm_wr_en;
    logic [7:0]  ifm_wr_addr;
    logic [31:0] ifm_wr_data;
    logic        wgt_wr_en;
    logic [1:0]  wgt_wr_pe;
    logic [3:0]  wgt_wr_addr;
    logic [31:0] wgt_wr_data;
    logic [1:0]  kernel_w;
    logic [4:0]  ifm_w;
    logic [1:0]  stride;
    logic        start_req;
    logic        start_ack;
    logic        busy;
    logic        ofm_valid;
    logic [31:0] ofm_data;
    logic [7:0]  ofm_idx;

    logic [31:0] ifm_ref [256];
    logic [31:0] wgt_ref [4][16];
    logic [31:0] exp_ofm [256];
    int          exp_count = 0;
    int          px_seen = 0;
    int          cur_k = 0;
    bit          sat_run = 1'b0;
    int          errors = 0;
    int          timeouts = 0;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifm_wr_en   (ifm_wr_en),
        .ifm_wr_addr (ifm_wr_addr),
        .ifm_wr_data (ifm_wr_data),
        .wgt_wr_en   (wgt_wr_en),
        .wgt_wr_pe   (wgt_wr_pe),
        .wgt_wr_addr (wgt_wr_addr),
        .wgt_wr_data (wgt_wr_data),
        .kernel_w    (kernel_w),
        .ifm_w       (ifm_w),
        .stride      (stride),
        .start_req   (start_req),
        .start_ack   (start_ack),
        .busy        (busy),
        .ofm_valid   (ofm_valid),
        .ofm_data    (ofm_data),
        .ofm_idx     (ofm_idx)
    );

    // pulses seen in the current run
    always @(posedge clk) begin
        if (start_req && !busy && !start_ack) begin
            px_seen <= 0;
        end else if (ofm_valid) begin
            px_seen <= px_seen + 1;
        end
    end

    // expected output word, straight from the convolution rules
    function automatic logic [31:0] model_pixel(int k, int w, int s, int idx);
        int          ow;
        int          oy;
        int          ox;
        int          sum;
        int          a;
        int          b;
        int          q;
        logic [31:0] px;
        logic [31:0] word;
        ow = (w - k) / s + 1;
        oy = idx / ow;
        ox = idx % ow;
        word = '0;
        for (int p = 0; p < 4; p++) begin
            sum = 0;
            for (int ky = 0; ky < k; ky++) begin
                for (int kx = 0; kx < k; kx++) begin
                    px = ifm_ref[(oy * s + ky) * w + ox * s + kx];
                    for (int l = 0; l < 4; l++) begin
                        a = $signed(px[l*8 +: 8]);
                        b = $signed(wgt_ref[p][ky*k + kx][l*8 +: 8]);
                        sum += a * b;
                    end
                end
            end
            q = sum >>> shift_q;
            if (q < 0) begin
                q = 0;
            end else if (q > act_max) begin
                q = act_max;
            end
            word[p*8 +: 8] = 8'(q);
        end
        return word;
    endfunction

    // lanes in -8..7 keep most sums inside the clamp range
    function automatic logic [31:0] small_pixel();
        logic [31:0] px;
        for (int l = 0; l < 4; l++) begin
            px[l*8 +: 8] = 8'($urandom % 16) - 8'd8;
        end
        return px;
    endfunction

    task automatic write_ifm(input int addr, input logic [31:0] data);
        @(negedge clk);
        wgt_wr_en     = 1'b0;
        ifm_wr_en     = 1'b1;
        ifm_wr_addr   = 8'(addr);
        ifm_wr_data   = data;
        ifm_ref[addr] = data;
    endtask

    task automatic write_wgt(input int pe, input int addr, input logic [31:0] data);
        @(negedge clk);
        ifm_wr_en         = 1'b0;
        wgt_wr_en         = 1'b1;
        wgt_wr_pe         = 2'(pe);
        wgt_wr_addr       = 4'(addr);
        wgt_wr_data       = data;
        wgt_ref[pe][addr] = data;
    endtask

    task automatic end_writes();
        @(negedge clk);
        ifm_wr_en = 1'b0;
        wgt_wr_en = 1'b0;
    endtask

    task automatic load_random(input int npix, input int k);
        for (int a = 0; a < npix; a++) begin
            write_ifm(a, small_pixel());
        end
        for (int p = 0; p < 4; p++) begin
            for (int t = 0; t < k * k; t++) begin
                write_wgt(p, t, small_pixel());
            end
        end
        end_writes();
    endtask

    // even pixels drive every channel high, odd pixels drive it negative
    task automatic load_saturating();
        for (int a = 0; a < 16; a++) begin
            write_ifm(a, a[0] ? 32'h8080_8080 : 32'h7f7f_7f7f);
        end
        for (int p = 0; p < 4; p++) begin
            write_wgt(p, 0, 32'h7f7f_7f7f);
        end
        end_writes();
    endtask

    task automatic run_conv(input int k, input int w, input int s);
        int n;
        exp_count = ((w - k) / s + 1) * ((w - k) / s + 1);
        for (int i = 0; i < exp_count; i++) begin
            exp_ofm[i] = model_pixel(k, w, s, i);
        end
        cur_k = k;
        @(negedge clk);
        kernel_w  = 2'(k);
        ifm_w     = 5'(w);
        stride    = 2'(s);
        start_req = 1'b1;
        n = 0;
        while (!start_ack && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!start_ack) begin
            timeouts++;
            $display("timeout: start_ack never rose in the %0dx%0d run", k, k);
        end
        // keep the request up so the ack has to hold
        repeat (3) @(negedge clk);
        start_req = 1'b0;
        n = 0;
        while (start_ack && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (start_ack) begin
            timeouts++;
            $display("timeout: start_ack stayed high after start_req fell");
        end
    endtask

    a_reset: assert property (@(posedge clk) !rst_n |=> !start_ack && !busy && !ofm_valid)
        else begin
            errors++;
            $display("Error: after reset start_ack=%h busy=%h ofm_valid=%h expected 0",
                $sampled(start_ack), $sampled(busy), $sampled(ofm_valid));
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid |-> ofm_data == exp_ofm[ofm_idx])
        else begin
            errors++;
            $display("Error: ofm_data got %h expected %h at ofm_idx %h",
                $sampled(ofm_data), exp_ofm[$sampled(ofm_idx)], $sampled(ofm_idx));
        end

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid |-> int'(ofm_idx) == px_seen)
        else begin
            errors++;
            $display("Error: ofm_idx got %h expected %h", $sampled(ofm_idx), $sampled(px_seen));
        end

    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start_ack) |-> $past(ofm_valid) && px_seen == exp_count)
        else begin
            errors++;
            $display("Error: ofm_valid count got %h expected %h at start_ack rise",
                $sampled(px_seen), exp_count);
        end

    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid && px_seen == exp_count - 1 |=> start_ack)
        else begin
            errors++;
            $display("Error: start_ack got %h expected 1 after last pixel", $sampled(start_ack));
        end

    a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        start_ack && start_req |=> start_ack)
        else begin
            errors++;
            $display("Error: start_ack got %h expected 1 while start_req high",
                $sampled(start_ack));
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        start_ack && !start_req |=> !start_ack)
        else begin
            errors++;
            $display("Error: start_ack got %h expected 0 after start_req fell",
                $sampled(start_ack));
        end

    a_busy_on: assert property (@(posedge clk) disable iff (!rst_n)
        start_req && !busy && !start_ack |=> busy)
        else begin
            errors++;
            $display("Error: busy got %h expected 1 after start", $sampled(busy));
        end

    a_busy_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> start_ack)
        else begin
            errors++;
            $display("Error: start_ack got %h expected 1 when busy fell", $sampled(start_ack));
        end

    a_clamp: assert property (@(posedge clk) disable iff (!rst_n)
        sat_run && ofm_valid |-> ofm_data == (ofm_idx[0] ? 32'h0 : 32'h6060_6060))
        else begin
            errors++;
            $display("Error: ofm_data got %h expected %h in saturating run",
                $sampled(ofm_data), $sampled(ofm_idx[0]) ? 32'h0 : 32'h6060_6060);
        end

    // 1x1 windows leave no gap between pixels
    a_burst: assert property (@(posedge clk) disable iff (!rst_n)
        cur_k == 1 && ofm_valid && px_seen < exp_count - 1 |=> ofm_valid)
        else begin
            errors++;
            $display("Error: ofm_valid got %h expected 1 in 1x1 burst", $sampled(ofm_valid));
        end

    initial begin
        int n;
        void'($urandom(32'h37d8_5fd9));
        ifm_wr_en   = 1'b0;
        ifm_wr_addr = '0;
        ifm_wr_data = '0;
        wgt_wr_en   = 1'b0;
        wgt_wr_pe   = '0;
        wgt_wr_addr = '0;
        wgt_wr_data = '0;
        kernel_w    = '0;
        ifm_w       = '0;
        stride      = '0;
        start_req   = 1'b0;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        load_random(64, 3);
        run_conv(3, 8, 1);

        load_random(256, 2);
        run_conv(2, 16, 2);

        load_saturating();
        sat_run = 1'b1;
        run_conv(1, 4, 1);
        sat_run = 1'b0;

        repeat (2) @(negedge clk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
